// ==== dv/tb_ex_top.sv ====
module tb_ex_top;

timeunit 1ns;
timeprecision 1ps;

localparam int mult_cycles = 4;
localparam int alu_ops = 20;
localparam int alu_reps = 20;
// two cycles per single op, stall plus two readbacks per multi-cycle op
localparam int est_cycles = 2 * alu_ops * alu_reps + 2 * 48 + 2 * 24
	+ 8 * (mult_cycles + 6) + 6 * (33 + 6) + 60;
localparam int max_cycles = 2 * est_cycles;

logic clk, rst, in_valid, we, flush;
cpu_pkg::op_t op;
logic [cpu_pkg::word_w-1:0] pc, reg1, reg2, imm;
logic [4:0] shamt;
logic [cpu_pkg::reg_addr_w-1:0] reg_addr1, reg_addr2, waddr, out_waddr;
logic out_valid, out_we, mem_ce, mem_we, stall_req;
logic exc_overflow, exc_trap, exc_unaligned, exc_invalid;
logic [cpu_pkg::word_w-1:0] out_wdata, mem_addr, mem_wdata, hi, lo;
logic [cpu_pkg::sel_w-1:0] mem_sel;

logic [63:0] model_hilo;
int errors = 0;
int n_checks = 0;
int cycles = 0;

ex_top #(.mult_cycles(mult_cycles)) UUT (
	.clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .pc(pc), .reg1(reg1),
	.reg2(reg2), .imm(imm), .shamt(shamt), .reg_addr1(reg_addr1), .reg_addr2(reg_addr2),
	.we(we), .waddr(waddr), .flush(flush), .out_valid(out_valid), .out_we(out_we),
	.out_waddr(out_waddr), .out_wdata(out_wdata), .mem_ce(mem_ce), .mem_we(mem_we),
	.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_sel(mem_sel),
	.exc_overflow(exc_overflow), .exc_trap(exc_trap), .exc_unaligned(exc_unaligned),
	.exc_invalid(exc_invalid), .stall_req(stall_req), .hi(hi), .lo(lo)
);

initial
begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

always @(posedge clk)
begin
	cycles <= cycles + 1;
	if (cycles >= max_cycles)
	begin
		$display("timeout: run did not finish within %0d cycles", max_cycles);
		$display("TESTS FAILED");
		$finish;
	end
end

task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
	n_checks++;
	if (act !== exp)
	begin
		errors++;
		$display("Fail %s: expected %h, actual %h", name, exp, act);
	end
endtask

function automatic logic [31:0] lead_count(input logic [31:0] v, input logic b);
	int n;
	n = 0;
	while (n < 32 && v[31-n] == b)
		n++;
	return 32'(n);
endfunction

function automatic logic [31:0] model_alu(input cpu_pkg::op_t o, input logic [31:0] a,
	input logic [31:0] b, input logic [31:0] i, input logic [4:0] sh, input logic [31:0] p);
	case (o)
		cpu_pkg::op_and:  return a & b;
		cpu_pkg::op_or:   return a | b;
		cpu_pkg::op_xor:  return a ^ b;
		cpu_pkg::op_nor:  return ~(a | b);
		cpu_pkg::op_lui:  return {i[15:0], 16'h0};
		cpu_pkg::op_add, cpu_pkg::op_addu: return a + b;
		cpu_pkg::op_sub, cpu_pkg::op_subu: return a - b;
		cpu_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		cpu_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
		cpu_pkg::op_sll:  return b << sh;
		cpu_pkg::op_srl:  return b >> sh;
		cpu_pkg::op_sra:  return $signed(b) >>> sh;
		cpu_pkg::op_sllv: return b << a[4:0];
		cpu_pkg::op_srlv: return b >> a[4:0];
		cpu_pkg::op_srav: return $signed(b) >>> a[4:0];
		cpu_pkg::op_clz:  return lead_count(a, 1'b0);
		cpu_pkg::op_clo:  return lead_count(a, 1'b1);
		cpu_pkg::op_jal:  return p + 32'd8;
		default:          return 32'd0;
	endcase
endfunction

// nibble per offset, offset 3 on the left
function automatic logic [3:0] lane_sel(input cpu_pkg::op_t o, input logic [1:0] ofs);
	logic [15:0] tab;
	case (o)
		cpu_pkg::op_lw, cpu_pkg::op_sw: tab = 16'hffff;
		cpu_pkg::op_lb, cpu_pkg::op_lbu, cpu_pkg::op_sb: tab = {4'b1000, 4'b0100, 4'b0010, 4'b0001};
		cpu_pkg::op_lh, cpu_pkg::op_lhu, cpu_pkg::op_sh: tab = {4'b1100, 4'b1100, 4'b0011, 4'b0011};
		cpu_pkg::op_lwl: tab = {4'b1111, 4'b1110, 4'b1100, 4'b1000};
		cpu_pkg::op_lwr: tab = {4'b0001, 4'b0011, 4'b0111, 4'b1111};
		cpu_pkg::op_swl: tab = {4'b1111, 4'b0111, 4'b0011, 4'b0001};
		cpu_pkg::op_swr: tab = {4'b1000, 4'b1100, 4'b1110, 4'b1111};
		default:         tab = 16'h0;
	endcase
	return tab[ofs*4 +: 4];
endfunction

function automatic logic [31:0] store_data(input cpu_pkg::op_t o, input logic [31:0] b,
	input logic [1:0] ofs);
	case (o)
		cpu_pkg::op_sb, cpu_pkg::op_swr: return b << (8 * ofs);
		cpu_pkg::op_sh:  return ofs[1] ? {b[15:0], 16'h0} : b;
		cpu_pkg::op_swl: return b >> (8 * (3 - ofs));
		default:         return b;
	endcase
endfunction

function automatic logic misaligned(input cpu_pkg::op_t o, input logic [1:0] ofs);
	if (o == cpu_pkg::op_lw || o == cpu_pkg::op_sw)
		return ofs != 2'b00;
	if (o == cpu_pkg::op_lh || o == cpu_pkg::op_lhu || o == cpu_pkg::op_sh)
		return ofs[0];
	return 1'b0;
endfunction

// {overflow, trap, unaligned, invalid}
function automatic logic [3:0] model_exc(input cpu_pkg::op_t o, input logic [31:0] a,
	input logic [31:0] b, input logic [31:0] i);
	longint s;
	logic ovf, trap;
	logic [31:0] addr;
	ovf = 1'b0;
	trap = 1'b0;
	addr = a + i;
	if (o == cpu_pkg::op_add || o == cpu_pkg::op_sub)
	begin
		s = (o == cpu_pkg::op_add) ? longint'($signed(a)) + longint'($signed(b))
			: longint'($signed(a)) - longint'($signed(b));
		ovf = (s > 64'sd2147483647) || (s < -64'sd2147483648);
	end
	case (o)
		cpu_pkg::op_teq:  trap = (a == b);
		cpu_pkg::op_tne:  trap = (a != b);
		cpu_pkg::op_tlt:  trap = ($signed(a) < $signed(b));
		cpu_pkg::op_tltu: trap = (a < b);
		default:          trap = 1'b0;
	endcase
	return {ovf, trap, misaligned(o, addr[1:0]), o == cpu_pkg::op_invalid};
endfunction

function automatic logic [63:0] model_hilo_next(input cpu_pkg::op_t o, input logic [31:0] a,
	input logic [31:0] b, input logic [63:0] old);
	longint sa, sb, q, r, p;
	sa = longint'($signed(a));
	sb = longint'($signed(b));
	p = sa * sb;
	case (o)
		cpu_pkg::op_mult:  return p;
		cpu_pkg::op_multu: return {32'h0, a} * {32'h0, b};
		cpu_pkg::op_madd:  return old + p;
		cpu_pkg::op_msub:  return old - p;
		default:
		begin
			// remainder in hi, quotient in lo
			if (b == 32'h0)
				return {a, 32'hffff_ffff};
			if (o == cpu_pkg::op_divu)
				return {a % b, a / b};
			q = sa / sb;
			r = sa % sb;
			return {r[31:0], q[31:0]};
		end
	endcase
endfunction

// starts right after a rising edge, returns on the edge that accepts the op
task automatic send(input cpu_pkg::op_t o, input logic [31:0] a, input logic [31:0] b,
	input logic [31:0] i, input logic [4:0] sh, input logic [31:0] p, input logic [4:0] ra1,
	input logic [4:0] ra2, input logic w, input logic [4:0] wa);
	in_valid <= 1'b1;
	op <= o;
	reg1 <= a;
	reg2 <= b;
	imm <= i;
	shamt <= sh;
	pc <= p;
	reg_addr1 <= ra1;
	reg_addr2 <= ra2;
	we <= w;
	waddr <= wa;
	@(negedge clk);
	while (stall_req)
		@(negedge clk);
	@(posedge clk);
endtask

// one op alone, returns at the negedge where its result is registered
task automatic exec(input cpu_pkg::op_t o, input logic [31:0] a, input logic [31:0] b,
	input logic [31:0] i, input logic [4:0] sh, input logic [31:0] p);
	@(posedge clk);
	send(o, a, b, i, sh, p, 5'd0, 5'd0, 1'b1, 5'd1);
	in_valid <= 1'b0;
	@(negedge clk);
endtask

task automatic reset_test();
	check("reset out_valid", 0, out_valid);
	check("reset out_we", 0, out_we);
	check("reset mem", 0, {mem_ce, mem_we});
	check("reset exc", 0, {exc_overflow, exc_trap, exc_unaligned, exc_invalid});
	check("reset stall_req", 0, stall_req);
	check("reset hilo", 0, {hi, lo});
endtask

task automatic alu_test();
	cpu_pkg::op_t ops [alu_ops];
	logic [31:0] a, b, i, p;
	logic [4:0] sh;
	ops = '{cpu_pkg::op_and, cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_nor,
		cpu_pkg::op_lui, cpu_pkg::op_add, cpu_pkg::op_addu, cpu_pkg::op_sub,
		cpu_pkg::op_subu, cpu_pkg::op_slt, cpu_pkg::op_sltu, cpu_pkg::op_sll,
		cpu_pkg::op_srl, cpu_pkg::op_sra, cpu_pkg::op_sllv, cpu_pkg::op_srlv,
		cpu_pkg::op_srav, cpu_pkg::op_clz, cpu_pkg::op_clo, cpu_pkg::op_jal};
	foreach (ops[k])
	begin
		for (int n = 0; n < alu_reps; n++)
		begin
			a = $urandom;
			b = $urandom;
			i = $urandom;
			p = $urandom & 32'hffff_fffc;
			sh = 5'($urandom);
			// spread the leading run lengths
			if (ops[k] == cpu_pkg::op_clz)
				a = a >> ($urandom % 33);
			if (ops[k] == cpu_pkg::op_clo)
				a = ~(a >> ($urandom % 33));
			exec(ops[k], a, b, i, sh, p);
			check($sformatf("alu %s", ops[k].name()), model_alu(ops[k], a, b, i, sh, p),
				out_wdata);
			check($sformatf("alu %s valid", ops[k].name()), 1, out_valid);
			check($sformatf("alu %s we", ops[k].name()), 1, out_we);
			check($sformatf("alu %s waddr", ops[k].name()), 1, out_waddr);
		end
	end
endtask

task automatic fwd_pair(input string name, input logic w, input logic [4:0] wa,
	input logic [4:0] ra1, input logic [4:0] ra2, input logic fwd1, input logic fwd2);
	logic [31:0] a, b, x, y, exp;
	a = $urandom;
	b = $urandom;
	x = $urandom;
	y = $urandom;
	exp = (fwd1 ? a + b : x) + (fwd2 ? a + b : y);
	@(posedge clk);
	send(cpu_pkg::op_addu, a, b, 32'd0, 5'd0, 32'd0, 5'd0, 5'd0, w, wa);
	send(cpu_pkg::op_addu, x, y, 32'd0, 5'd0, 32'd0, ra1, ra2, 1'b1, 5'd7);
	in_valid <= 1'b0;
	@(negedge clk);
	check(name, exp, out_wdata);
	check({name, " waddr"}, 7, out_waddr);
endtask

task automatic fwd_test();
	fwd_pair("fwd operand 1", 1'b1, 5'd5, 5'd5, 5'd3, 1'b1, 1'b0);
	fwd_pair("fwd operand 2", 1'b1, 5'd9, 5'd4, 5'd9, 1'b0, 1'b1);
	fwd_pair("fwd both", 1'b1, 5'd12, 5'd12, 5'd12, 1'b1, 1'b1);
	fwd_pair("fwd r0 blocked", 1'b1, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
	fwd_pair("fwd we low", 1'b0, 5'd5, 5'd5, 5'd5, 1'b0, 1'b0);
endtask

task automatic exc_case(input string name, input cpu_pkg::op_t o, input logic [31:0] a,
	input logic [31:0] b, input logic [31:0] i);
	exec(o, a, b, i, 5'd0, 32'd0);
	check(name, model_exc(o, a, b, i),
		{exc_overflow, exc_trap, exc_unaligned, exc_invalid});
endtask

task automatic exc_test();
	exc_case("add overflow", cpu_pkg::op_add, 32'h7fff_ffff, 32'h1, 32'h0);
	exc_case("add no overflow", cpu_pkg::op_add, 32'h7fff_ffff, 32'hffff_ffff, 32'h0);
	exc_case("addu wraps", cpu_pkg::op_addu, 32'h7fff_ffff, 32'h1, 32'h0);
	exc_case("sub overflow", cpu_pkg::op_sub, 32'h8000_0000, 32'h1, 32'h0);
	exc_case("sub no overflow", cpu_pkg::op_sub, 32'h5, 32'h7, 32'h0);
	exc_case("teq true", cpu_pkg::op_teq, 32'h1234, 32'h1234, 32'h0);
	exc_case("teq false", cpu_pkg::op_teq, 32'h1234, 32'h1235, 32'h0);
	exc_case("tne true", cpu_pkg::op_tne, 32'h1, 32'h2, 32'h0);
	exc_case("tne false", cpu_pkg::op_tne, 32'h9, 32'h9, 32'h0);
	exc_case("tlt true", cpu_pkg::op_tlt, 32'hffff_ffff, 32'h1, 32'h0);
	exc_case("tlt false", cpu_pkg::op_tlt, 32'h1, 32'hffff_ffff, 32'h0);
	exc_case("tltu true", cpu_pkg::op_tltu, 32'h1, 32'hffff_ffff, 32'h0);
	exc_case("tltu false", cpu_pkg::op_tltu, 32'hffff_ffff, 32'h1, 32'h0);
	exc_case("invalid op", cpu_pkg::op_invalid, 32'h0, 32'h0, 32'h0);
	exc_case("lw misaligned", cpu_pkg::op_lw, 32'h1000, 32'h0, 32'h2);
	exc_case("lh misaligned", cpu_pkg::op_lh, 32'h1000, 32'h0, 32'h1);
	exc_case("lw aligned", cpu_pkg::op_lw, 32'h1000, 32'h0, 32'h4);
endtask

task automatic mem_test();
	cpu_pkg::op_t ops [12];
	logic [31:0] a, b, i, addr;
	logic is_store;
	string name;
	ops = '{cpu_pkg::op_lb, cpu_pkg::op_lbu, cpu_pkg::op_lh, cpu_pkg::op_lhu,
		cpu_pkg::op_lw, cpu_pkg::op_lwl, cpu_pkg::op_lwr, cpu_pkg::op_sb,
		cpu_pkg::op_sh, cpu_pkg::op_sw, cpu_pkg::op_swl, cpu_pkg::op_swr};
	foreach (ops[k])
	begin
		for (int ofs = 0; ofs < 4; ofs++)
		begin
			a = $urandom & 32'hffff_fffc;
			b = $urandom;
			i = ($urandom & 32'hffff_fffc) | 32'(ofs);
			addr = a + i;
			is_store = ops[k] inside {cpu_pkg::op_sb, cpu_pkg::op_sh, cpu_pkg::op_sw,
				cpu_pkg::op_swl, cpu_pkg::op_swr};
			exec(ops[k], a, b, i, 5'd0, 32'd0);
			name = $sformatf("mem %s offset %0d", ops[k].name(), ofs);
			check({name, " ce"}, 1, mem_ce);
			check({name, " we"}, is_store, mem_we);
			check({name, " addr"}, addr, mem_addr);
			check({name, " sel"}, lane_sel(ops[k], addr[1:0]), mem_sel);
			check({name, " unaligned"}, misaligned(ops[k], addr[1:0]), exc_unaligned);
			if (is_store)
				check({name, " wdata"}, store_data(ops[k], b, addr[1:0]), mem_wdata);
		end
	end
endtask

// mfhi right behind the op reads the pending write, mflo reads the register
task automatic muldiv_case(input string name, input cpu_pkg::op_t o, input logic [31:0] a,
	input logic [31:0] b);
	logic [63:0] exp;
	exp = model_hilo_next(o, a, b, model_hilo);
	@(posedge clk);
	send(o, a, b, 32'd0, 5'd0, 32'd0, 5'd0, 5'd0, 1'b0, 5'd0);
	send(cpu_pkg::op_mfhi, 32'd0, 32'd0, 32'd0, 5'd0, 32'd0, 5'd0, 5'd0, 1'b1, 5'd2);
	in_valid <= 1'b0;
	@(negedge clk);
	check({name, " mfhi"}, exp[63:32], out_wdata);
	@(posedge clk);
	send(cpu_pkg::op_mflo, 32'd0, 32'd0, 32'd0, 5'd0, 32'd0, 5'd0, 5'd0, 1'b1, 5'd3);
	in_valid <= 1'b0;
	@(negedge clk);
	check({name, " mflo"}, exp[31:0], out_wdata);
	check({name, " hi lo"}, exp, {hi, lo});
	model_hilo = exp;
endtask

task automatic muldiv_test();
	for (int n = 0; n < 2; n++)
	begin
		muldiv_case("mult", cpu_pkg::op_mult, $urandom, $urandom);
		muldiv_case("multu", cpu_pkg::op_multu, $urandom, $urandom);
		muldiv_case("madd", cpu_pkg::op_madd, $urandom, $urandom);
		muldiv_case("msub", cpu_pkg::op_msub, $urandom, $urandom);
		muldiv_case("div", cpu_pkg::op_div, $urandom, $urandom >> ($urandom % 32));
		muldiv_case("divu", cpu_pkg::op_divu, $urandom, $urandom >> ($urandom % 32));
	end
	muldiv_case("div by zero", cpu_pkg::op_div, $urandom, 32'h0);
	muldiv_case("divu by zero", cpu_pkg::op_divu, $urandom, 32'h0);
endtask

task automatic flush_test();
	@(posedge clk);
	in_valid <= 1'b1;
	op <= cpu_pkg::op_div;
	reg1 <= $urandom;
	reg2 <= $urandom | 32'h1;
	reg_addr1 <= 5'd0;
	reg_addr2 <= 5'd0;
	we <= 1'b0;
	repeat (6) @(posedge clk);
	@(negedge clk);
	check("flush divide busy", 1, stall_req);
	@(posedge clk);
	flush <= 1'b1;
	in_valid <= 1'b0;
	@(posedge clk);
	flush <= 1'b0;
	@(negedge clk);
	check("flush stall_req", 0, stall_req);
	check("flush out_valid", 0, out_valid);
	// the aborted divide must never commit
	repeat (40) @(posedge clk);
	@(negedge clk);
	check("flush hi lo kept", model_hilo, {hi, lo});
endtask

initial
begin
	void'($urandom(63151));
	rst = 1'b1;
	in_valid = 1'b0;
	op = cpu_pkg::op_nop;
	pc = '0;
	reg1 = '0;
	reg2 = '0;
	imm = '0;
	shamt = '0;
	reg_addr1 = '0;
	reg_addr2 = '0;
	we = 1'b0;
	waddr = '0;
	flush = 1'b0;
	model_hilo = '0;
	repeat (4) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	reset_test();
	alu_test();
	fwd_test();
	exc_test();
	mem_test();
	muldiv_test();
	flush_test();
	$display("checks %0d, errors %0d", n_checks, errors);
	if (errors == 0)
		$display("TESTS PASSED");
	else
		$display("TESTS FAILED");
	$finish;
end

endmodule

// ==== files.f ====
hw/cpu_pkg.sv
hw/ex_count_bit.sv
hw/ex_multi_cyc.sv
hw/ex_mem_req.sv
hw/cpu_ex.sv
hw/ex_mem_reg.sv
hw/hilo_reg.sv
hw/ex_top.sv
dv/tb_ex_top.sv

// ==== hw/cpu_ex.sv ====
module cpu_ex #(
	parameter int mult_cycles = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           flush,
	input  logic                           in_valid,
	input  cpu_pkg::op_t                   op,
	input  logic [cpu_pkg::word_w-1:0]     pc,
	input  logic [cpu_pkg::word_w-1:0]     reg1,
	input  logic [cpu_pkg::word_w-1:0]     reg2,
	input  logic [cpu_pkg::word_w-1:0]     imm,
	input  logic [4:0]                     shamt,
	input  logic [cpu_pkg::reg_addr_w-1:0] reg_addr1,
	input  logic [cpu_pkg::reg_addr_w-1:0] reg_addr2,
	input  logic                           fwd_we,
	input  logic [cpu_pkg::reg_addr_w-1:0] fwd_waddr,
	input  logic [cpu_pkg::word_w-1:0]     fwd_wdata,
	input  logic                           fwd_hilo_we,
	input  logic [2*cpu_pkg::word_w-1:0]   fwd_hilo,
	input  logic [2*cpu_pkg::word_w-1:0]   hilo,
	output logic [cpu_pkg::word_w-1:0]     ret,
	output logic                           hilo_we,
	output logic [2*cpu_pkg::word_w-1:0]   hilo_wdata,
	output logic                           mem_ce,
	output logic                           mem_we,
	output logic [cpu_pkg::word_w-1:0]     mem_addr,
	output logic [cpu_pkg::word_w-1:0]     mem_wdata,
	output logic [cpu_pkg::sel_w-1:0]      mem_sel,
	output logic                           exc_overflow,
	output logic                           exc_trap,
	output logic                           exc_unaligned,
	output logic                           exc_invalid,
	output logic                           accept,
	output logic                           stall_req
);

logic [cpu_pkg::word_w-1:0] src1, src2, hi, lo, add_u, sub_u, clz_cnt, clo_cnt;
logic [2*cpu_pkg::word_w-1:0] hilo_safe, mc_ret;
logic signed_lt, unsigned_lt, ov_add, ov_sub, multi_op, mc_start, mc_busy;

// r0 is never forwarded
assign src1 = (fwd_we && fwd_waddr == reg_addr1 && reg_addr1 != '0) ? fwd_wdata : reg1;
assign src2 = (fwd_we && fwd_waddr == reg_addr2 && reg_addr2 != '0) ? fwd_wdata : reg2;
assign hilo_safe = fwd_hilo_we ? fwd_hilo : hilo;
assign {hi, lo} = hilo_safe;

assign add_u = src1 + src2;
assign sub_u = src1 - src2;
assign signed_lt = (src1[31] != src2[31]) ? src1[31] : sub_u[31];
assign unsigned_lt = (src1 < src2);
assign ov_add = (src1[31] == src2[31]) & (src1[31] ^ add_u[31]);
assign ov_sub = (src1[31] ^ src2[31]) & (src1[31] ^ sub_u[31]);

ex_count_bit u_clz (.bit_val(1'b0), .val(src1), .count(clz_cnt));
ex_count_bit u_clo (.bit_val(1'b1), .val(src1), .count(clo_cnt));

assign multi_op = op inside {cpu_pkg::op_mult, cpu_pkg::op_multu, cpu_pkg::op_madd,
	cpu_pkg::op_msub, cpu_pkg::op_div, cpu_pkg::op_divu};
assign mc_start = in_valid & multi_op & ~flush;

ex_multi_cyc #(.mult_cycles(mult_cycles)) u_multi_cyc (
	.clk, .rst, .flush, .start(mc_start), .op, .reg1(src1), .reg2(src2),
	.hilo(hilo_safe), .ret(mc_ret), .busy(mc_busy)
);

ex_mem_req u_mem_req (
	.op, .reg1(src1), .reg2(src2), .imm, .ce(mem_ce), .we(mem_we), .addr(mem_addr),
	.wdata(mem_wdata), .sel(mem_sel), .unaligned(exc_unaligned)
);

assign stall_req = mc_busy;
assign accept = in_valid & ~stall_req;

always_comb
begin
	unique case (op)
		cpu_pkg::op_and:  ret = src1 & src2;
		cpu_pkg::op_or:   ret = src1 | src2;
		cpu_pkg::op_xor:  ret = src1 ^ src2;
		cpu_pkg::op_nor:  ret = ~(src1 | src2);
		cpu_pkg::op_lui:  ret = {imm[15:0], 16'b0};
		cpu_pkg::op_add, cpu_pkg::op_addu: ret = add_u;
		cpu_pkg::op_sub, cpu_pkg::op_subu: ret = sub_u;
		cpu_pkg::op_slt:  ret = {{(cpu_pkg::word_w-1){1'b0}}, signed_lt};
		cpu_pkg::op_sltu: ret = {{(cpu_pkg::word_w-1){1'b0}}, unsigned_lt};
		cpu_pkg::op_sll:  ret = src2 << shamt;
		cpu_pkg::op_srl:  ret = src2 >> shamt;
		cpu_pkg::op_sra:  ret = $signed(src2) >>> shamt;
		cpu_pkg::op_sllv: ret = src2 << src1[4:0];
		cpu_pkg::op_srlv: ret = src2 >> src1[4:0];
		cpu_pkg::op_srav: ret = $signed(src2) >>> src1[4:0];
		cpu_pkg::op_clz:  ret = clz_cnt;
		cpu_pkg::op_clo:  ret = clo_cnt;
		cpu_pkg::op_mfhi: ret = hi;
		cpu_pkg::op_mflo: ret = lo;
		cpu_pkg::op_jal:  ret = pc + cpu_pkg::link_offset;
		default:          ret = '0;
	endcase
end

always_comb
begin
	hilo_we = multi_op;
	hilo_wdata = mc_ret;
	if (op == cpu_pkg::op_mthi)
	begin
		hilo_we = 1'b1;
		hilo_wdata = {src1, lo};
	end else if (op == cpu_pkg::op_mtlo)
	begin
		hilo_we = 1'b1;
		hilo_wdata = {hi, src1};
	end
end

assign exc_overflow = ((op == cpu_pkg::op_add) & ov_add) | ((op == cpu_pkg::op_sub) & ov_sub);
assign exc_invalid = (op == cpu_pkg::op_invalid);

always_comb
begin
	unique case (op)
		cpu_pkg::op_teq:  exc_trap = (src1 == src2);
		cpu_pkg::op_tne:  exc_trap = (src1 != src2);
		cpu_pkg::op_tlt:  exc_trap = signed_lt;
		cpu_pkg::op_tltu: exc_trap = unsigned_lt;
		default:          exc_trap = 1'b0;
	endcase
end

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;
	localparam int sel_w = 4;

	// return address skips the delay slot
	localparam logic [word_w-1:0] link_offset = 32'd8;

	typedef enum logic [5:0] {
		op_nop,
		op_and,
		op_or,
		op_xor,
		op_nor,
		op_lui,
		op_add,
		op_addu,
		op_sub,
		op_subu,
		op_slt,
		op_sltu,
		op_sll,
		op_srl,
		op_sra,
		op_sllv,
		op_srlv,
		op_srav,
		op_clz,
		op_clo,
		op_mfhi,
		op_mflo,
		op_mthi,
		op_mtlo,
		op_mult,
		op_multu,
		op_madd,
		op_msub,
		op_div,
		op_divu,
		op_jal,
		op_lb,
		op_lbu,
		op_lh,
		op_lhu,
		op_lw,
		op_lwl,
		op_lwr,
		op_sb,
		op_sh,
		op_sw,
		op_swl,
		op_swr,
		op_teq,
		op_tne,
		op_tlt,
		op_tltu,
		op_invalid
	} op_t;

endpackage

// ==== hw/ex_count_bit.sv ====
module ex_count_bit (
	input  logic                       bit_val,
	input  logic [cpu_pkg::word_w-1:0] val,
	output logic [cpu_pkg::word_w-1:0] count
);

logic found;

// scan from msb, stop at first bit that differs
always_comb
begin
	count = cpu_pkg::word_w'(cpu_pkg::word_w);
	found = 1'b0;
	for (int i = cpu_pkg::word_w - 1; i >= 0; i--)
	begin
		if (!found && val[i] != bit_val)
		begin
			count = cpu_pkg::word_w'(cpu_pkg::word_w - 1 - i);
			found = 1'b1;
		end
	end
end

endmodule

// ==== hw/ex_mem_reg.sv ====
module ex_mem_reg (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           flush,
	input  logic                           accept,
	input  logic                           we,
	input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
	input  logic [cpu_pkg::word_w-1:0]     wdata,
	input  logic                           mem_ce,
	input  logic                           mem_we,
	input  logic [cpu_pkg::word_w-1:0]     mem_addr,
	input  logic [cpu_pkg::word_w-1:0]     mem_wdata,
	input  logic [cpu_pkg::sel_w-1:0]      mem_sel,
	input  logic                           exc_overflow,
	input  logic                           exc_trap,
	input  logic                           exc_unaligned,
	input  logic                           exc_invalid,
	input  logic                           hilo_we,
	input  logic [2*cpu_pkg::word_w-1:0]   hilo_wdata,
	output logic                           out_valid,
	output logic                           out_we,
	output logic [cpu_pkg::reg_addr_w-1:0] out_waddr,
	output logic [cpu_pkg::word_w-1:0]     out_wdata,
	output logic                           out_mem_ce,
	output logic                           out_mem_we,
	output logic [cpu_pkg::word_w-1:0]     out_mem_addr,
	output logic [cpu_pkg::word_w-1:0]     out_mem_wdata,
	output logic [cpu_pkg::sel_w-1:0]      out_mem_sel,
	output logic                           out_exc_overflow,
	output logic                           out_exc_trap,
	output logic                           out_exc_unaligned,
	output logic                           out_exc_invalid,
	output logic                           out_hilo_we,
	output logic [2*cpu_pkg::word_w-1:0]   out_hilo_wdata
);

// bubble on stall or flush
always_ff @(posedge clk)
begin
	if (rst || flush || !accept)
	begin
		out_valid <= 1'b0;
		out_we <= 1'b0;
		out_mem_ce <= 1'b0;
		out_mem_we <= 1'b0;
		out_exc_overflow <= 1'b0;
		out_exc_trap <= 1'b0;
		out_exc_unaligned <= 1'b0;
		out_exc_invalid <= 1'b0;
		out_hilo_we <= 1'b0;
	end else
	begin
		out_valid <= 1'b1;
		out_we <= we;
		out_mem_ce <= mem_ce;
		out_mem_we <= mem_we;
		out_exc_overflow <= exc_overflow;
		out_exc_trap <= exc_trap;
		out_exc_unaligned <= exc_unaligned;
		out_exc_invalid <= exc_invalid;
		out_hilo_we <= hilo_we;
	end
end

always_ff @(posedge clk)
begin
	if (accept)
	begin
		out_waddr <= waddr;
		out_wdata <= wdata;
		out_mem_addr <= mem_addr;
		out_mem_wdata <= mem_wdata;
		out_mem_sel <= mem_sel;
		out_hilo_wdata <= hilo_wdata;
	end
end

// an unaligned flag only comes with a memory access
assert property (@(posedge clk) disable iff (rst) out_exc_unaligned |-> out_mem_ce);

endmodule

// ==== hw/ex_mem_req.sv ====
module ex_mem_req (
	input  cpu_pkg::op_t                op,
	input  logic [cpu_pkg::word_w-1:0]  reg1,
	input  logic [cpu_pkg::word_w-1:0]  reg2,
	input  logic [cpu_pkg::word_w-1:0]  imm,
	output logic                        ce,
	output logic                        we,
	output logic [cpu_pkg::word_w-1:0]  addr,
	output logic [cpu_pkg::word_w-1:0]  wdata,
	output logic [cpu_pkg::sel_w-1:0]   sel,
	output logic                        unaligned
);

logic [1:0] ofs;

assign addr = reg1 + imm;
assign ofs = addr[1:0];

// little-endian lanes, byte 0 on sel[0]
always_comb
begin
	ce = 1'b1;
	we = op inside {cpu_pkg::op_sb, cpu_pkg::op_sh, cpu_pkg::op_sw,
		cpu_pkg::op_swl, cpu_pkg::op_swr};
	wdata = reg2;
	unaligned = 1'b0;
	unique case (op)
	cpu_pkg::op_lw, cpu_pkg::op_sw:
	begin
		sel = 4'b1111;
		unaligned = |ofs;
	end
	cpu_pkg::op_lb, cpu_pkg::op_lbu, cpu_pkg::op_sb:
	begin
		sel = 4'b0001 << ofs;
		wdata = reg2 << {ofs, 3'b000};
	end
	cpu_pkg::op_lh, cpu_pkg::op_lhu, cpu_pkg::op_sh:
	begin
		sel = ofs[1] ? 4'b1100 : 4'b0011;
		wdata = ofs[1] ? (reg2 << 16) : reg2;
		unaligned = ofs[0];
	end
	cpu_pkg::op_lwl:
		sel = 4'b1111 << ~ofs;
	cpu_pkg::op_lwr:
		sel = 4'b1111 >> ofs;
	cpu_pkg::op_swl:
	begin
		sel = 4'b1111 >> ~ofs;
		wdata = reg2 >> {~ofs, 3'b000};
	end
	cpu_pkg::op_swr:
	begin
		sel = 4'b1111 << ofs;
		wdata = reg2 << {ofs, 3'b000};
	end
	default:
	begin
		ce = 1'b0;
		sel = '0;
		wdata = '0;
	end
	endcase
	assert (!ce || sel != '0);
end

endmodule

// ==== hw/ex_multi_cyc.sv ====
module ex_multi_cyc #(
	parameter int mult_cycles = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         flush,
	input  logic                         start,
	input  cpu_pkg::op_t                 op,
	input  logic [cpu_pkg::word_w-1:0]   reg1,
	input  logic [cpu_pkg::word_w-1:0]   reg2,
	input  logic [2*cpu_pkg::word_w-1:0] hilo,
	output logic [2*cpu_pkg::word_w-1:0] ret,
	output logic                         busy
);

localparam int max_busy = (mult_cycles > 33) ? mult_cycles + 1 : 34;

typedef enum logic [1:0] {st_idle, st_mult, st_div, st_done} state_t;

state_t state;
logic [cpu_pkg::word_w-1:0] cnt;
logic [2*cpu_pkg::word_w-1:0] prod_s, prod_u, mul_res;
logic [cpu_pkg::word_w-1:0] quot, rem, divisor, dividend, quot_fix, rem_fix;
logic [cpu_pkg::word_w:0] trial;
logic is_div, div_zero, sign_q, sign_r, is_signed;

assign prod_s = $signed(reg1) * $signed(reg2);
assign prod_u = reg1 * reg2;
assign is_signed = (op == cpu_pkg::op_div);
assign trial = {rem, quot[cpu_pkg::word_w-1]} - {1'b0, divisor};

always_ff @(posedge clk)
begin
	if (rst || flush)
	begin
		state <= st_idle;
		cnt <= '0;
	end else
	begin
		unique case (state)
		st_idle:
		begin
			cnt <= 1;
			if (start && (op == cpu_pkg::op_div || op == cpu_pkg::op_divu))
			begin
				cnt <= '0;
				state <= st_div;
			end else if (start)
			begin
				state <= (mult_cycles > 1) ? st_mult : st_done;
			end
		end
		st_mult:
		begin
			cnt <= cnt + 1;
			if (cnt == cpu_pkg::word_w'(mult_cycles - 1))
				state <= st_done;
		end
		st_div:
		begin
			cnt <= cnt + 1;
			if (cnt == cpu_pkg::word_w'(cpu_pkg::word_w - 1))
				state <= st_done;
		end
		st_done:
			state <= st_idle;
		endcase
	end
end

// operands latched at start, one quotient bit per div cycle
always_ff @(posedge clk)
begin
	if (state == st_idle && start)
	begin
		is_div <= (op == cpu_pkg::op_div || op == cpu_pkg::op_divu);
		div_zero <= (reg2 == '0);
		dividend <= reg1;
		sign_q <= is_signed & (reg1[cpu_pkg::word_w-1] ^ reg2[cpu_pkg::word_w-1]);
		sign_r <= is_signed & reg1[cpu_pkg::word_w-1];
		quot <= (is_signed && reg1[cpu_pkg::word_w-1]) ? -reg1 : reg1;
		divisor <= (is_signed && reg2[cpu_pkg::word_w-1]) ? -reg2 : reg2;
		rem <= '0;
		unique case (op)
			cpu_pkg::op_madd:  mul_res <= hilo + prod_s;
			cpu_pkg::op_msub:  mul_res <= hilo - prod_s;
			cpu_pkg::op_multu: mul_res <= prod_u;
			default:           mul_res <= prod_s;
		endcase
	end else if (state == st_div)
	begin
		if (!trial[cpu_pkg::word_w])
		begin
			rem <= trial[cpu_pkg::word_w-1:0];
			quot <= {quot[cpu_pkg::word_w-2:0], 1'b1};
		end else
		begin
			rem <= {rem[cpu_pkg::word_w-2:0], quot[cpu_pkg::word_w-1]};
			quot <= {quot[cpu_pkg::word_w-2:0], 1'b0};
		end
	end
end

assign quot_fix = sign_q ? -quot : quot;
assign rem_fix = sign_r ? -rem : rem;

// hi holds remainder, lo holds quotient
always_comb
begin
	if (!is_div)
		ret = mul_res;
	else if (div_zero)
		ret = {dividend, {cpu_pkg::word_w{1'b1}}};
	else
		ret = {rem_fix, quot_fix};
end

assign busy = (state == st_idle && start) || state == st_mult || state == st_div;

assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> ##[1:max_busy] !busy);

endmodule

// ==== hw/ex_top.sv ====
module ex_top #(
	parameter int mult_cycles = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           in_valid,
	input  cpu_pkg::op_t                   op,
	input  logic [cpu_pkg::word_w-1:0]     pc,
	input  logic [cpu_pkg::word_w-1:0]     reg1,
	input  logic [cpu_pkg::word_w-1:0]     reg2,
	input  logic [cpu_pkg::word_w-1:0]     imm,
	input  logic [4:0]                     shamt,
	input  logic [cpu_pkg::reg_addr_w-1:0] reg_addr1,
	input  logic [cpu_pkg::reg_addr_w-1:0] reg_addr2,
	input  logic                           we,
	input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
	input  logic                           flush,
	output logic                           out_valid,
	output logic                           out_we,
	output logic [cpu_pkg::reg_addr_w-1:0] out_waddr,
	output logic [cpu_pkg::word_w-1:0]     out_wdata,
	output logic                           mem_ce,
	output logic                           mem_we,
	output logic [cpu_pkg::word_w-1:0]     mem_addr,
	output logic [cpu_pkg::word_w-1:0]     mem_wdata,
	output logic [cpu_pkg::sel_w-1:0]      mem_sel,
	output logic                           exc_overflow,
	output logic                           exc_trap,
	output logic                           exc_unaligned,
	output logic                           exc_invalid,
	output logic                           stall_req,
	output logic [cpu_pkg::word_w-1:0]     hi,
	output logic [cpu_pkg::word_w-1:0]     lo
);

logic accept, ex_hilo_we, ex_mem_ce, ex_mem_we, reg_hilo_we;
logic ex_overflow, ex_trap, ex_unaligned, ex_invalid;
logic [cpu_pkg::word_w-1:0] ex_ret, ex_mem_addr, ex_mem_wdata;
logic [cpu_pkg::sel_w-1:0] ex_mem_sel;
logic [2*cpu_pkg::word_w-1:0] ex_hilo_wdata, reg_hilo_wdata;

cpu_ex #(.mult_cycles(mult_cycles)) u_cpu_ex (
	.clk, .rst, .flush, .in_valid, .op, .pc, .reg1, .reg2, .imm, .shamt,
	.reg_addr1, .reg_addr2,
	.fwd_we(out_we), .fwd_waddr(out_waddr), .fwd_wdata(out_wdata),
	.fwd_hilo_we(reg_hilo_we), .fwd_hilo(reg_hilo_wdata), .hilo({hi, lo}),
	.ret(ex_ret), .hilo_we(ex_hilo_we), .hilo_wdata(ex_hilo_wdata),
	.mem_ce(ex_mem_ce), .mem_we(ex_mem_we), .mem_addr(ex_mem_addr),
	.mem_wdata(ex_mem_wdata), .mem_sel(ex_mem_sel),
	.exc_overflow(ex_overflow), .exc_trap(ex_trap), .exc_unaligned(ex_unaligned),
	.exc_invalid(ex_invalid), .accept, .stall_req
);

ex_mem_reg u_ex_mem_reg (
	.clk, .rst, .flush, .accept, .we, .waddr, .wdata(ex_ret),
	.mem_ce(ex_mem_ce), .mem_we(ex_mem_we), .mem_addr(ex_mem_addr),
	.mem_wdata(ex_mem_wdata), .mem_sel(ex_mem_sel),
	.exc_overflow(ex_overflow), .exc_trap(ex_trap), .exc_unaligned(ex_unaligned),
	.exc_invalid(ex_invalid), .hilo_we(ex_hilo_we), .hilo_wdata(ex_hilo_wdata),
	.out_valid, .out_we, .out_waddr, .out_wdata,
	.out_mem_ce(mem_ce), .out_mem_we(mem_we), .out_mem_addr(mem_addr),
	.out_mem_wdata(mem_wdata), .out_mem_sel(mem_sel),
	.out_exc_overflow(exc_overflow), .out_exc_trap(exc_trap),
	.out_exc_unaligned(exc_unaligned), .out_exc_invalid(exc_invalid),
	.out_hilo_we(reg_hilo_we), .out_hilo_wdata(reg_hilo_wdata)
);

hilo_reg u_hilo_reg (
	.clk, .rst, .we(reg_hilo_we), .wdata(reg_hilo_wdata), .hi, .lo
);

endmodule

// ==== hw/hilo_reg.sv ====
module hilo_reg (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         we,
	input  logic [2*cpu_pkg::word_w-1:0] wdata,
	output logic [cpu_pkg::word_w-1:0]   hi,
	output logic [cpu_pkg::word_w-1:0]   lo
);

logic [2*cpu_pkg::word_w-1:0] hilo_q;

always_ff @(posedge clk)
begin
	if (rst)
		hilo_q <= '0;
	else if (we)
		hilo_q <= wdata;
end

// upper word is hi
assign hi = hilo_q[2*cpu_pkg::word_w-1:cpu_pkg::word_w];
assign lo = hilo_q[cpu_pkg::word_w-1:0];

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_ex_top -o sim_ex_top
./obj_dir/sim_ex_top | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
